// File: logic/xfer_pkg.sv
package xfer_pkg;

	// byte address on the DRAM side
	typedef logic [31:0] dram_addr_t;
	// filter slot in the upper 6 bits, channel in the lower 7
	typedef logic [12:0] weight_sram_addr_t;
	// tile row in the upper 6 bits, column word in the lower 7
	typedef logic [12:0] input_sram_addr_t;
	// bank bit on top, word below
	typedef logic [7:0] buf_addr_t;
	typedef logic [9:0] map_dim_t;
	typedef logic [5:0] tile_len_t;
	typedef logic [9:0] filter_cnt_t;

	typedef enum logic [2:0] {
		wt_idle,
		wt_group,
		wt_load,
		wt_wait,
		wt_pass,
		wt_finished
	} weight_state_t;

	typedef enum logic [2:0] {
		in_idle,
		in_setup,
		in_request,
		in_dma_wait,
		in_copy_wait,
		in_compute_wait,
		in_next_tile
	} input_state_t;

	// word offset of the filter weights in DRAM
	localparam int weight_base = 'h100000;
	localparam int tile_span = 52;
	localparam int tile_step = 50;
	localparam int filter_group = 32;
	// 3x3 kernel
	localparam int kernel_area = 9;
	localparam int addr_shift = 2;
	localparam int sram_col_bits = 7;

endpackage

// File: logic/weight_loader.sv
`timescale 1ns/1ps

module weight_loader (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          run,
	input  xfer_pkg::filter_cnt_t         kernel_num,
	input  xfer_pkg::map_dim_t            channel,
	input  logic                          dma_done,
	input  logic                          pass_done,
	output logic                          weight_req,
	output xfer_pkg::dram_addr_t          weight_dram_start,
	output xfer_pkg::dram_addr_t          weight_dram_end,
	output xfer_pkg::weight_sram_addr_t   weight_sram_start,
	output xfer_pkg::weight_sram_addr_t   weight_sram_end,
	output logic                          pass_start,
	output logic                          done
);
	import xfer_pkg::*;

	weight_state_t state;
	filter_cnt_t group_base;
	logic [5:0] slot;
	filter_cnt_t filter_idx;
	dram_addr_t filter_len;
	dram_addr_t filter_word;
	map_dim_t chan_last;
	logic slot_last;
	logic group_last;

	// global filter index of the current slot
	assign filter_idx = group_base + filter_cnt_t'(slot);
	assign filter_len = dram_addr_t'(kernel_area) * dram_addr_t'(channel);
	assign filter_word = dram_addr_t'(weight_base) + dram_addr_t'(filter_idx) * filter_len;

	assign weight_dram_start = filter_word << addr_shift;
	assign weight_dram_end = (filter_word + filter_len - 32'd1) << addr_shift;

	// one SRAM row per filter, one word per channel
	assign chan_last = channel - map_dim_t'(1);
	assign weight_sram_start = {slot, {sram_col_bits{1'b0}}};
	assign weight_sram_end = {slot, chan_last[sram_col_bits-1:0]};

	// group ends at slot 31 or at the last filter overall
	assign slot_last = (int'(filter_idx) + 1 >= int'(kernel_num)) ||
		(int'(slot) == filter_group - 1);
	assign group_last = int'(group_base) + filter_group >= int'(kernel_num);

	assign weight_req = (state == wt_load);
	assign done = (state == wt_finished);

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			state <= wt_idle;
			group_base <= '0;
			slot <= '0;
			pass_start <= 1'b0;
		end
		else
		begin
			pass_start <= 1'b0;
			case (state)
				wt_idle:
				begin
					if (run)
					begin
						group_base <= '0;
						state <= wt_group;
					end
				end
				wt_group:
				begin
					slot <= '0;
					state <= wt_load;
				end
				wt_load:
					state <= wt_wait;
				wt_wait:
				begin
					if (dma_done)
					begin
						if (slot_last)
						begin
							pass_start <= 1'b1;
							state <= wt_pass;
						end
						else
						begin
							slot <= slot + 6'd1;
							state <= wt_load;
						end
					end
				end
				wt_pass:
				begin
					// input side walks every tile for this group
					if (pass_done)
					begin
						if (group_last)
							state <= wt_finished;
						else
						begin
							group_base <= group_base + filter_cnt_t'(filter_group);
							state <= wt_group;
						end
					end
				end
				wt_finished:
					state <= wt_finished;
				default:
					state <= wt_idle;
			endcase
		end
	end

endmodule

// File: logic/tile_sequencer.sv
`timescale 1ns/1ps

module tile_sequencer (
	input  logic                  clk,
	input  logic                  rst,
	input  xfer_pkg::map_dim_t    map_size,
	input  logic                  tile_restart,
	input  logic                  tile_next,
	output xfer_pkg::map_dim_t    tile_col,
	output xfer_pkg::map_dim_t    tile_row,
	output xfer_pkg::tile_len_t   col_length,
	output xfer_pkg::tile_len_t   row_length,
	output logic                  tile_last
);
	import xfer_pkg::*;

	logic col_last;
	logic row_last;

	// a tile reaching the map edge is the last in its direction
	assign col_last = int'(tile_col) + tile_span >= int'(map_size);
	assign row_last = int'(tile_row) + tile_span >= int'(map_size);

	assign col_length = col_last ? tile_len_t'(map_size - tile_col) : tile_len_t'(tile_span);
	assign row_length = row_last ? tile_len_t'(map_size - tile_row) : tile_len_t'(tile_span);

	assign tile_last = col_last && row_last;

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			tile_col <= '0;
			tile_row <= '0;
		end
		else if (tile_restart)
		begin
			tile_col <= '0;
			tile_row <= '0;
		end
		else if (tile_next)
		begin
			// row-major walk, tiles overlap by two pixels
			if (col_last)
			begin
				tile_col <= '0;
				tile_row <= tile_row + map_dim_t'(tile_step);
			end
			else
				tile_col <= tile_col + map_dim_t'(tile_step);
		end
	end

endmodule

// File: logic/input_loader.sv
`timescale 1ns/1ps

module input_loader (
	input  logic                         clk,
	input  logic                         rst,
	input  xfer_pkg::map_dim_t           channel,
	input  xfer_pkg::map_dim_t           map_size,
	input  logic                         pass_start,
	input  logic                         dma_done,
	input  logic                         buffer2sram_done,
	input  logic                         tile_done,
	input  xfer_pkg::map_dim_t           tile_col,
	input  xfer_pkg::map_dim_t           tile_row,
	input  xfer_pkg::tile_len_t          col_length,
	input  xfer_pkg::tile_len_t          row_length,
	input  logic                         tile_last,
	output logic                         input_req,
	output xfer_pkg::dram_addr_t         input_dram_start,
	output xfer_pkg::dram_addr_t         input_dram_end,
	output xfer_pkg::buf_addr_t          buf_addr_start,
	output xfer_pkg::buf_addr_t          buf_addr_end,
	output xfer_pkg::input_sram_addr_t   input_sram_addr_start,
	output logic                         buffer2sram_start,
	output logic                         compute_run,
	output xfer_pkg::map_dim_t           cur_channel,
	output xfer_pkg::tile_len_t          row_end,
	output xfer_pkg::tile_len_t          col_end,
	output logic                         tile_restart,
	output logic                         tile_next,
	output logic                         pass_done
);
	import xfer_pkg::*;

	input_state_t state;
	logic bank;
	tile_len_t row_off;
	map_dim_t cur_row;
	dram_addr_t plane_words;
	dram_addr_t row_word;
	logic [6:0] buf_word_last;
	logic row_last;
	logic chan_last;

	// absolute map row of the row being loaded
	assign cur_row = tile_row + map_dim_t'(row_off);
	assign plane_words = dram_addr_t'(map_size) * dram_addr_t'(map_size);
	assign row_word = dram_addr_t'(cur_channel) * plane_words +
		dram_addr_t'(cur_row) * dram_addr_t'(map_size) + dram_addr_t'(tile_col);

	assign input_dram_start = row_word << addr_shift;
	assign input_dram_end = (row_word + dram_addr_t'(col_length) - 32'd1) << addr_shift;

	// four pixels per buffer word
	assign buf_word_last = {3'b000, col_length[5:2]} - 7'd1;

	assign row_last = (row_off == row_length - tile_len_t'(1));
	assign chan_last = (cur_channel == channel - map_dim_t'(1));

	assign input_req = (state == in_request);
	assign tile_restart = (state == in_setup);
	assign tile_next = (state == in_next_tile);

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			state <= in_idle;
			// toggled before first use, so bank 0 goes first
			bank <= 1'b1;
			row_off <= '0;
			cur_channel <= '0;
			buf_addr_start <= '0;
			buf_addr_end <= '0;
			input_sram_addr_start <= '0;
			buffer2sram_start <= 1'b0;
			compute_run <= 1'b0;
			row_end <= '0;
			col_end <= '0;
			pass_done <= 1'b0;
		end
		else
		begin
			buffer2sram_start <= 1'b0;
			compute_run <= 1'b0;
			pass_done <= 1'b0;
			case (state)
				in_idle:
				begin
					if (pass_start)
						state <= in_setup;
				end
				in_setup, in_next_tile:
				begin
					// origin settles in the sequencer this cycle
					cur_channel <= '0;
					row_off <= '0;
					state <= in_request;
				end
				in_request:
					state <= in_dma_wait;
				in_dma_wait:
				begin
					if (dma_done)
					begin
						bank <= ~bank;
						buf_addr_start <= {~bank, 7'd0};
						buf_addr_end <= {~bank, buf_word_last};
						input_sram_addr_start <= {row_off, {sram_col_bits{1'b0}}};
						buffer2sram_start <= 1'b1;
						state <= in_copy_wait;
					end
				end
				in_copy_wait:
				begin
					if (buffer2sram_done)
					begin
						if (row_last)
						begin
							row_end <= row_length - tile_len_t'(1);
							col_end <= col_length - tile_len_t'(1);
							compute_run <= 1'b1;
							state <= in_compute_wait;
						end
						else
						begin
							row_off <= row_off + tile_len_t'(1);
							state <= in_request;
						end
					end
				end
				in_compute_wait:
				begin
					if (tile_done)
					begin
						if (!chan_last)
						begin
							cur_channel <= cur_channel + map_dim_t'(1);
							row_off <= '0;
							state <= in_request;
						end
						else if (tile_last)
						begin
							pass_done <= 1'b1;
							state <= in_idle;
						end
						else
							state <= in_next_tile;
					end
				end
				default:
					state <= in_idle;
			endcase
		end
	end

endmodule

// File: logic/dma_request_mux.sv
`timescale 1ns/1ps

module dma_request_mux (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          weight_req,
	input  xfer_pkg::dram_addr_t          weight_dram_start,
	input  xfer_pkg::dram_addr_t          weight_dram_end,
	input  xfer_pkg::weight_sram_addr_t   weight_sram_start,
	input  xfer_pkg::weight_sram_addr_t   weight_sram_end,
	input  logic                          input_req,
	input  xfer_pkg::dram_addr_t          input_dram_start,
	input  xfer_pkg::dram_addr_t          input_dram_end,
	output logic                          dma_start,
	output xfer_pkg::dram_addr_t          dram_addr_start,
	output xfer_pkg::dram_addr_t          dram_addr_end,
	output logic                          sram_type,
	output xfer_pkg::weight_sram_addr_t   weight_sram_addr_start,
	output xfer_pkg::weight_sram_addr_t   weight_sram_addr_end
);

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			dma_start <= 1'b0;
			dram_addr_start <= '0;
			dram_addr_end <= '0;
			sram_type <= 1'b0;
			weight_sram_addr_start <= '0;
			weight_sram_addr_end <= '0;
		end
		else
		begin
			dma_start <= weight_req || input_req;
			// addresses hold until the next request
			if (weight_req)
			begin
				dram_addr_start <= weight_dram_start;
				dram_addr_end <= weight_dram_end;
				sram_type <= 1'b1;
				weight_sram_addr_start <= weight_sram_start;
				weight_sram_addr_end <= weight_sram_end;
			end
			else if (input_req)
			begin
				dram_addr_start <= input_dram_start;
				dram_addr_end <= input_dram_end;
				sram_type <= 1'b0;
			end
		end
	end

endmodule

// File: logic/transfer_controller.sv
`timescale 1ns/1ps

module transfer_controller (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          run,
	input  xfer_pkg::filter_cnt_t         kernel_num,
	input  xfer_pkg::map_dim_t            channel,
	input  xfer_pkg::map_dim_t            map_size,
	input  logic                          dma_done,
	input  logic                          buffer2sram_done,
	input  logic                          tile_done,
	output logic                          dma_start,
	output xfer_pkg::dram_addr_t          dram_addr_start,
	output xfer_pkg::dram_addr_t          dram_addr_end,
	output logic                          sram_type,
	output xfer_pkg::weight_sram_addr_t   weight_sram_addr_start,
	output xfer_pkg::weight_sram_addr_t   weight_sram_addr_end,
	output xfer_pkg::buf_addr_t           buf_addr_start,
	output xfer_pkg::buf_addr_t           buf_addr_end,
	output xfer_pkg::input_sram_addr_t    input_sram_addr_start,
	output logic                          buffer2sram_start,
	output logic                          compute_run,
	output xfer_pkg::map_dim_t            cur_channel,
	output xfer_pkg::tile_len_t           row_end,
	output xfer_pkg::tile_len_t           col_end,
	output logic                          done
);
	import xfer_pkg::*;

	logic weight_req;
	dram_addr_t weight_dram_start;
	dram_addr_t weight_dram_end;
	weight_sram_addr_t weight_sram_start;
	weight_sram_addr_t weight_sram_end;
	logic input_req;
	dram_addr_t input_dram_start;
	dram_addr_t input_dram_end;
	logic pass_start;
	logic pass_done;
	logic tile_restart;
	logic tile_next;
	map_dim_t tile_col;
	map_dim_t tile_row;
	tile_len_t col_length;
	tile_len_t row_length;
	logic tile_last;

	// filter groups, one full tile pass per group
	weight_loader i_weight_loader (
		.clk               (clk),
		.rst               (rst),
		.run               (run),
		.kernel_num        (kernel_num),
		.channel           (channel),
		.dma_done          (dma_done),
		.pass_done         (pass_done),
		.weight_req        (weight_req),
		.weight_dram_start (weight_dram_start),
		.weight_dram_end   (weight_dram_end),
		.weight_sram_start (weight_sram_start),
		.weight_sram_end   (weight_sram_end),
		.pass_start        (pass_start),
		.done              (done)
	);

	tile_sequencer i_tile_sequencer (
		.clk          (clk),
		.rst          (rst),
		.map_size     (map_size),
		.tile_restart (tile_restart),
		.tile_next    (tile_next),
		.tile_col     (tile_col),
		.tile_row     (tile_row),
		.col_length   (col_length),
		.row_length   (row_length),
		.tile_last    (tile_last)
	);

	input_loader i_input_loader (
		.clk                   (clk),
		.rst                   (rst),
		.channel               (channel),
		.map_size              (map_size),
		.pass_start            (pass_start),
		.dma_done              (dma_done),
		.buffer2sram_done      (buffer2sram_done),
		.tile_done             (tile_done),
		.tile_col              (tile_col),
		.tile_row              (tile_row),
		.col_length            (col_length),
		.row_length            (row_length),
		.tile_last             (tile_last),
		.input_req             (input_req),
		.input_dram_start      (input_dram_start),
		.input_dram_end        (input_dram_end),
		.buf_addr_start        (buf_addr_start),
		.buf_addr_end          (buf_addr_end),
		.input_sram_addr_start (input_sram_addr_start),
		.buffer2sram_start     (buffer2sram_start),
		.compute_run           (compute_run),
		.cur_channel           (cur_channel),
		.row_end               (row_end),
		.col_end               (col_end),
		.tile_restart          (tile_restart),
		.tile_next             (tile_next),
		.pass_done             (pass_done)
	);

	// single DMA port shared by both loaders
	dma_request_mux i_dma_request_mux (
		.clk                    (clk),
		.rst                    (rst),
		.weight_req             (weight_req),
		.weight_dram_start      (weight_dram_start),
		.weight_dram_end        (weight_dram_end),
		.weight_sram_start      (weight_sram_start),
		.weight_sram_end        (weight_sram_end),
		.input_req              (input_req),
		.input_dram_start       (input_dram_start),
		.input_dram_end         (input_dram_end),
		.dma_start              (dma_start),
		.dram_addr_start        (dram_addr_start),
		.dram_addr_end          (dram_addr_end),
		.sram_type              (sram_type),
		.weight_sram_addr_start (weight_sram_addr_start),
		.weight_sram_addr_end   (weight_sram_addr_end)
	);

endmodule

// File: verif/transfer_controller_asserts.sv
`timescale 1ns/1ps

module transfer_controller_asserts (
	input logic clk,
	input logic rst,
	input logic dma_start,
	input logic weight_req,
	input logic input_req,
	input logic done
);

	// count of failed assertions
	int assert_fails = 0;

	// one start per transfer
	dma_start_pulse: assert property (@(posedge clk) disable iff (rst) dma_start |=> !dma_start)
	else
	begin
		$error("dma_start held high for more than one cycle");
		assert_fails++;
	end

	// both loaders share one DMA port
	req_exclusive: assert property (@(posedge clk) disable iff (rst) !(weight_req && input_req))
	else
	begin
		$error("weight_req and input_req active together");
		assert_fails++;
	end

	done_sticky: assert property (@(posedge clk) disable iff (rst) done |=> done)
	else
	begin
		$error("done fell without a reset");
		assert_fails++;
	end

endmodule

bind transfer_controller transfer_controller_asserts i_asserts (
	.clk        (clk),
	.rst        (rst),
	.dma_start  (dma_start),
	.weight_req (weight_req),
	.input_req  (input_req),
	.done       (done)
);

// File: verif/tb_transfer_controller.sv
`timescale 1ns/1ps

module tb_transfer_controller;
	import xfer_pkg::*;

	localparam int ev_weight = 0;
	localparam int ev_input = 1;
	localparam int ev_copy = 2;
	localparam int ev_compute = 3;

	logic clk = 1'b0;
	logic rst;
	logic run;
	filter_cnt_t kernel_num;
	map_dim_t channel;
	map_dim_t map_size;
	logic dma_done;
	logic buffer2sram_done;
	logic tile_done;
	logic dma_start;
	dram_addr_t dram_addr_start;
	dram_addr_t dram_addr_end;
	logic sram_type;
	weight_sram_addr_t weight_sram_addr_start;
	weight_sram_addr_t weight_sram_addr_end;
	buf_addr_t buf_addr_start;
	buf_addr_t buf_addr_end;
	input_sram_addr_t input_sram_addr_start;
	logic buffer2sram_start;
	logic compute_run;
	map_dim_t cur_channel;
	tile_len_t row_end;
	tile_len_t col_end;
	logic done;

	// expected events, oldest first
	int exp_kind[$];
	logic [31:0] exp_a[$];
	logic [31:0] exp_b[$];
	logic [31:0] exp_c[$];
	logic [31:0] exp_d[$];

	logic [31:0] lfsr = 32'hb71f2b71;
	int error_count = 0;
	int watch_count = 0;
	int watch_limit = 1000;

	transfer_controller i_dut (.*);

	always #5 clk = ~clk;

	task automatic fail_run();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	function automatic int random_bits(input int count);
		int value;
		int i;
		value = 0;
		for (i = 0; i < count; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			value = (value << 1) | int'(lfsr[0]);
		end
		return value;
	endfunction

	function automatic void push_event(input int kind, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] c, input logic [31:0] d);
		exp_kind.push_back(kind);
		exp_a.push_back(a);
		exp_b.push_back(b);
		exp_c.push_back(c);
		exp_d.push_back(d);
	endfunction

	// ordered event list for one run: weights per group, then every tile pass
	function automatic void build_expected(input int kn, input int ch, input int ms);
		int base;
		int p;
		int w;
		int fl;
		int tr;
		int tc;
		int rl;
		int cl;
		int c;
		int r;
		int word;
		logic last_row;
		logic last_col;
		logic bank;
		logic [5:0] slot;
		logic [6:0] chan_word;
		logic [6:0] buf_last;
		logic [5:0] row_field;
		fl = kernel_area * ch;
		bank = 1'b1;
		chan_word = 7'(ch - 1);
		for (base = 0; base < kn; base = base + filter_group)
		begin
			for (p = 0; p < filter_group && base + p < kn; p++)
			begin
				w = weight_base + (base + p) * fl;
				slot = 6'(p);
				push_event(ev_weight, w << addr_shift, (w + fl - 1) << addr_shift,
					{slot, 7'd0}, {slot, chan_word});
			end
			tr = 0;
			do
			begin
				last_row = (tr + tile_span >= ms);
				rl = last_row ? ms - tr : tile_span;
				tc = 0;
				do
				begin
					last_col = (tc + tile_span >= ms);
					cl = last_col ? ms - tc : tile_span;
					buf_last = 7'(cl / 4 - 1);
					for (c = 0; c < ch; c++)
					begin
						for (r = tr; r < tr + rl; r++)
						begin
							word = c * ms * ms + r * ms + tc;
							push_event(ev_input, word << addr_shift,
								(word + cl - 1) << addr_shift, 0, 0);
							// banks alternate over the whole run
							bank = ~bank;
							row_field = 6'(r - tr);
							push_event(ev_copy, {bank, 7'd0}, {bank, buf_last},
								{row_field, 7'd0}, 0);
						end
						push_event(ev_compute, c, rl - 1, cl - 1, 0);
					end
					tc = tc + tile_step;
				end while (!last_col);
				tr = tr + tile_step;
			end while (!last_row);
		end
	endfunction

	task automatic compare_dram_addr(input string name, input dram_addr_t got,
		input dram_addr_t exp);
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic compare_weight_sram_addr(input string name, input weight_sram_addr_t got,
		input weight_sram_addr_t exp);
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic compare_buf_addr(input string name, input buf_addr_t got,
		input buf_addr_t exp);
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic compare_input_sram_addr(input string name, input input_sram_addr_t got,
		input input_sram_addr_t exp);
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic compare_tile_len(input string name, input tile_len_t got,
		input tile_len_t exp);
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic compare_map_dim(input string name, input map_dim_t got,
		input map_dim_t exp);
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic pop_event(output int kind, output logic [31:0] a, output logic [31:0] b,
		output logic [31:0] c, output logic [31:0] d);
		if (exp_kind.size() == 0)
		begin
			error_count++;
			$display("%0t: the DUT issued an event after the expected list ran out", $time);
			fail_run();
		end
		kind = exp_kind.pop_front();
		a = exp_a.pop_front();
		b = exp_b.pop_front();
		c = exp_c.pop_front();
		d = exp_d.pop_front();
	endtask

	task automatic check_observed(input int seen);
		int kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		pop_event(kind, a, b, c, d);
		if ((seen == ev_input && kind != ev_weight && kind != ev_input) ||
			(seen != ev_input && kind != seen))
		begin
			error_count++;
			$display("%0t: event kind %0d seen while kind %0d was expected", $time, seen, kind);
			fail_run();
		end
		if (kind == ev_weight || kind == ev_input)
		begin
			compare_bit("sram_type", sram_type, kind == ev_weight);
			compare_dram_addr("dram_addr_start", dram_addr_start, a);
			compare_dram_addr("dram_addr_end", dram_addr_end, b);
		end
		if (kind == ev_weight)
		begin
			compare_weight_sram_addr("weight_sram_addr_start", weight_sram_addr_start, c[12:0]);
			compare_weight_sram_addr("weight_sram_addr_end", weight_sram_addr_end, d[12:0]);
		end
		if (kind == ev_copy)
		begin
			compare_buf_addr("buf_addr_start", buf_addr_start, a[7:0]);
			compare_buf_addr("buf_addr_end", buf_addr_end, b[7:0]);
			compare_input_sram_addr("input_sram_addr_start", input_sram_addr_start, c[12:0]);
		end
		if (kind == ev_compute)
		begin
			compare_map_dim("cur_channel", cur_channel, a[9:0]);
			compare_tile_len("row_end", row_end, b[5:0]);
			compare_tile_len("col_end", col_end, c[5:0]);
		end
	endtask

	// outputs settle after the rising edge, checked in mid-cycle
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (i_dut.i_asserts.assert_fails != 0)
			begin
				$display("%0t: a bound protocol assertion failed", $time);
				fail_run();
			end
			if (done && exp_kind.size() != 0)
			begin
				$display("%0t: done rose with %0d events still expected", $time, exp_kind.size());
				fail_run();
			end
			if (dma_start)
				check_observed(ev_input);
			if (buffer2sram_start)
				check_observed(ev_copy);
			if (compute_run)
				check_observed(ev_compute);
		end
	end

	// responders: done pulse 1 to 8 cycles after each start
	always @(negedge clk)
	begin
		if (!rst && dma_start)
		begin
			repeat (1 + random_bits(3)) @(posedge clk);
			dma_done <= 1'b1;
			@(posedge clk);
			dma_done <= 1'b0;
		end
	end

	always @(negedge clk)
	begin
		if (!rst && buffer2sram_start)
		begin
			repeat (1 + random_bits(3)) @(posedge clk);
			buffer2sram_done <= 1'b1;
			@(posedge clk);
			buffer2sram_done <= 1'b0;
		end
	end

	always @(negedge clk)
	begin
		if (!rst && compute_run)
		begin
			repeat (1 + random_bits(3)) @(posedge clk);
			tile_done <= 1'b1;
			@(posedge clk);
			tile_done <= 1'b0;
		end
	end

	always @(posedge clk)
	begin
		watch_count = watch_count + 1;
		if (watch_count > watch_limit)
		begin
			$display("timeout: test not finished within %0d cycles", watch_limit);
			fail_run();
		end
	end

	task automatic run_test(input int kn, input int ch, input int ms);
		@(posedge clk);
		rst <= 1'b1;
		kernel_num <= filter_cnt_t'(kn);
		channel <= map_dim_t'(ch);
		map_size <= map_dim_t'(ms);
		repeat (3) @(posedge clk);
		build_expected(kn, ch, ms);
		watch_count = 0;
		watch_limit = 40 * exp_kind.size() + 1000;
		rst <= 1'b0;
		@(posedge clk);
		run <= 1'b1;
		@(posedge clk);
		run <= 1'b0;
		while (!done)
			@(posedge clk);
		repeat (5) @(posedge clk);
		if (exp_kind.size() != 0)
		begin
			$display("test ended with %0d expected events never seen", exp_kind.size());
			fail_run();
		end
	endtask

	initial
	begin
		rst = 1'b1;
		run = 1'b0;
		kernel_num = '0;
		channel = map_dim_t'(1);
		map_size = map_dim_t'(10);
		dma_done = 1'b0;
		buffer2sram_done = 1'b0;
		tile_done = 1'b0;
		// single tile, one group
		run_test(5, 2, 10);
		// four overlapping tiles
		run_test(3, 2, 60);
		// two filter groups, 32 and 8
		run_test(40, 1, 10);
		if (error_count == 0)
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
		else
			fail_run();
	end

endmodule

// File: files.f
logic/xfer_pkg.sv
logic/weight_loader.sv
logic/tile_sequencer.sv
logic/input_loader.sv
logic/dma_request_mux.sv
logic/transfer_controller.sv
verif/transfer_controller_asserts.sv
verif/tb_transfer_controller.sv

// File: Bender.yml
package:
  name: transfer_controller

dependencies: {}

sources:
  - logic/xfer_pkg.sv
  - logic/weight_loader.sv
  - logic/tile_sequencer.sv
  - logic/input_loader.sv
  - logic/dma_request_mux.sv
  - logic/transfer_controller.sv
  - target: test
    files:
      - verif/transfer_controller_asserts.sv
      - verif/tb_transfer_controller.sv
